//--- bench/bus_input.txt
# columns (hex): op status addr wdata strobes{ior,iow,memr,memw} dev rdata
# op 0 bus cycle, 1 port C read with live tone, 2 audio enable = wdata bit 0, 3 speaker held at rdata bit 0, 4 tone duty
0 0 300 00 0 7 00
0 1 300 00 8 7 00
0 2 300 00 4 7 00
0 3 300 00 0 7 00
0 4 300 00 2 7 00
0 5 300 00 2 7 00
0 6 300 00 1 7 00
0 7 300 00 0 7 00
0 1 000 00 8 0 00
0 1 020 00 8 1 00
0 1 040 00 8 2 00
0 1 060 00 8 3 00
0 1 080 00 8 4 00
0 1 0a0 00 8 5 00
0 1 0c0 00 8 7 00
0 1 100 00 8 7 00
0 5 060 00 2 7 00
0 2 061 a5 4 3 00
0 1 061 00 8 3 a5
0 1 060 00 8 3 2c
0 1 063 00 8 3 00
0 1 040 00 8 2 00
1 1 062 00 8 3 06
0 2 041 00 4 2 00
0 1 061 00 8 3 a5
0 2 061 00 4 3 00
0 1 060 00 8 3 00
0 1 062 00 8 3 2e
0 2 061 04 4 3 00
0 1 062 00 8 3 26
0 2 061 03 4 3 00
2 7 000 01 0 7 00
4 7 000 00 0 7 00
0 2 061 02 4 3 00
3 7 000 00 0 7 00
0 2 061 00 4 3 00
3 7 000 00 0 7 01
0 2 061 03 4 3 00
2 7 000 00 0 7 00
3 7 000 00 0 7 01

//--- bench/io_board_tb.sv
// testbench for io_board that replays bus cycles from bench/bus_input.txt and measures the tone
`timescale 1ns/1ps
`default_nettype none

module io_board_tb
   import io_board_pkg::*;
();

   // short tone so the duty check fits in a few hundred clocks
   localparam logic [TONE_CNT_W-1:0] TB_RELOAD    = 12'd19;
   localparam logic [TONE_CNT_W-1:0] TB_THRESHOLD = 12'd10;
   localparam int TONE_PERIOD = 2 * (TB_RELOAD + 1);                // clocks per tone period
   localparam int TONE_HIGH   = 2 * (TB_RELOAD - TB_THRESHOLD + 1); // clocks of raw tone high
   localparam int DUTY_CLOCKS = 200;
   // speaker is high while the raw tone is low
   localparam int DUTY_HIGH   = DUTY_CLOCKS * (TONE_PERIOD - TONE_HIGH) / TONE_PERIOD;
   localparam int HOLD_CLOCKS = 40;

   // operation codes of the data file
   localparam int OP_BUS        = 0;
   localparam int OP_PORTC_LIVE = 1; // port C read while the tone runs
   localparam int OP_AUDIO      = 2;
   localparam int OP_HOLD       = 3;
   localparam int OP_DUTY       = 4;

   logic                 clk;
   logic                 reset_n;
   bus_status_e          status_i;
   logic [IO_ADDR_W-1:0] addr_i;
   logic [DATA_W-1:0]    wr_data_i;
   logic                 audio_en_i;
   logic                 ior_o;
   logic                 iow_o;
   logic                 memr_o;
   logic                 memw_o;
   io_dev_e              dev_sel_o;
   logic [DATA_W-1:0]    rd_data_o;
   logic                 speaker_o;

   // one entry per data line
   int                   rec_op[$];
   bus_status_e          rec_status[$];
   logic [IO_ADDR_W-1:0] rec_addr[$];
   logic [DATA_W-1:0]    rec_wdata[$];
   logic [3:0]           rec_strobes[$];
   io_dev_e              rec_dev[$];
   logic [DATA_W-1:0]    rec_rdata[$];

   int mismatch_errors = 0;
   int other_errors    = 0;
   int cycle_count     = 0;
   int cycle_limit     = 0; // set once the file is read

   io_board #(
      .TONE_RELOAD    (TB_RELOAD),
      .TONE_THRESHOLD (TB_THRESHOLD)
   ) u_dut (
      .clk        (clk),
      .reset_n    (reset_n),
      .status_i   (status_i),
      .addr_i     (addr_i),
      .wr_data_i  (wr_data_i),
      .audio_en_i (audio_en_i),
      .ior_o      (ior_o),
      .iow_o      (iow_o),
      .memr_o     (memr_o),
      .memw_o     (memw_o),
      .dev_sel_o  (dev_sel_o),
      .rd_data_o  (rd_data_o),
      .speaker_o  (speaker_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // run limit from the number of data lines
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Timeout: bus sequence still running after %0d cycles", cycle_count);
         $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
         $display("TEST FAIL");
         $finish;
      end
   end

   task automatic read_stimulus();
      int    fd;
      int    n;
      string line;
      int    op, st, addr, wdata, strb, dev, rdata;
      fd = $fopen("bench/bus_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open bench/bus_input.txt for reading");
         other_errors++;
         return;
      end
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n == 0) break;
         if (line.len() == 0 || line[0] == "#") continue; // column notes
         n = $sscanf(line, "%h %h %h %h %h %h %h", op, st, addr, wdata, strb, dev, rdata);
         if (n != 7) continue;
         rec_op.push_back(op);
         rec_status.push_back(bus_status_e'(st[2:0]));
         rec_addr.push_back(addr[IO_ADDR_W-1:0]);
         rec_wdata.push_back(wdata[DATA_W-1:0]);
         rec_strobes.push_back(strb[3:0]);
         rec_dev.push_back(io_dev_e'(dev[2:0]));
         rec_rdata.push_back(rdata[DATA_W-1:0]);
      end
      $fclose(fd);
      if (rec_op.size() == 0) begin
         $display("No bus cycles found in bench/bus_input.txt");
         other_errors++;
      end
   endtask

   task automatic check_strobes(input logic [3:0] exp);
      logic [3:0] act;
      act = {ior_o, iow_o, memr_o, memw_o};
      if (act !== exp) begin
         $display("Mismatch at %0t: {ior_o,iow_o,memr_o,memw_o} expected %b, got %b",
                  $time, exp, act);
         mismatch_errors++;
      end
   endtask

   task automatic check_dev(input io_dev_e exp, input io_dev_e act);
      if (act !== exp) begin
         $display("Mismatch at %0t: dev_sel_o expected %s, got %s (%0d)",
                  $time, exp.name(), act.name(), act);
         mismatch_errors++;
      end
   endtask

   task automatic check_data(input string sig, input logic [DATA_W-1:0] exp,
                             input logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("Mismatch at %0t: %s expected 0x%h, got 0x%h", $time, sig, exp, act);
         mismatch_errors++;
      end
   endtask

   task automatic check_bit(input string sig, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Mismatch at %0t: %s expected %b, got %b", $time, sig, exp, act);
         mismatch_errors++;
      end
   endtask

   // three clocks of the cycle then passive plus a random idle gap
   task automatic run_bus_cycle(input int idx);
      int unsigned gap;
      @(posedge clk);
      status_i  <= rec_status[idx];
      addr_i    <= rec_addr[idx];
      wr_data_i <= rec_wdata[idx];
      @(posedge clk);
      @(negedge clk); // strobes registered on the edge before
      check_strobes(rec_strobes[idx]);
      check_dev(rec_dev[idx], dev_sel_o);
      if (rec_op[idx] == OP_PORTC_LIVE) begin
         // tone bits move so only switches and top bits are fixed
         check_data("rd_data_o[7:6,3:0]", rec_rdata[idx] & 8'hcf, rd_data_o & 8'hcf);
         check_bit("rd_data_o[5]", ~rd_data_o[4], rd_data_o[5]);
      end else begin
         check_data("rd_data_o", rec_rdata[idx], rd_data_o);
      end
      repeat (2) @(posedge clk);
      status_i <= BUS_PASSIVE;
      gap = $urandom % 4;
      repeat (gap) @(posedge clk);
   endtask

   task automatic set_audio(input int idx);
      logic [DATA_W-1:0] w;
      w = rec_wdata[idx];
      @(posedge clk);
      audio_en_i <= w[0];
   endtask

   task automatic check_speaker_hold(input int idx);
      logic [DATA_W-1:0] exp;
      exp = rec_rdata[idx];
      repeat (HOLD_CLOCKS) begin
         @(negedge clk);
         check_bit("speaker_o", exp[0], speaker_o);
      end
   endtask

   task automatic check_tone_duty();
      int high;
      high = 0;
      repeat (DUTY_CLOCKS) begin
         @(negedge clk);
         if (speaker_o) high++;
      end
      if (high < DUTY_HIGH - TONE_PERIOD || high > DUTY_HIGH + TONE_PERIOD) begin
         $display("Speaker tone duty wrong at %0t: high for %0d of %0d clocks, expected %0d",
                  $time, high, DUTY_CLOCKS, DUTY_HIGH);
         other_errors++;
      end
   endtask

   initial begin
      status_i   = BUS_PASSIVE;
      addr_i     = '0;
      wr_data_i  = '0;
      audio_en_i = 1'b0;
      reset_n    = 1'b0;
      void'($urandom(32'h1ed9));
      read_stimulus();
      cycle_limit = 4 * rec_op.size() + 2000;
      repeat (5) @(posedge clk);
      reset_n <= 1'b1;
      @(negedge clk);
      check_strobes(4'b0000);
      check_dev(DEV_NONE, dev_sel_o);
      check_bit("speaker_o", 1'b1, speaker_o);
      for (int i = 0; i < rec_op.size(); i++) begin
         case (rec_op[i])
            OP_BUS, OP_PORTC_LIVE: run_bus_cycle(i);
            OP_AUDIO:              set_audio(i);
            OP_HOLD:               check_speaker_hold(i);
            OP_DUTY:               check_tone_duty();
            default: begin
               $display("Unknown operation %0d on data line %0d", rec_op[i], i);
               other_errors++;
            end
         endcase
      end
      repeat (2) @(posedge clk);
      $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
      if (mismatch_errors == 0 && other_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
source/io_board_pkg.sv
source/bus_cmd_decode.sv
source/io_port_decode.sv
source/tone_timer.sv
source/ppi_ports.sv
source/io_board.sv
bench/io_board_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the io_board testbench with Verilator, runs it and checks the log for the pass line
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=io_board_sim

verilator --binary --timing --assert -Wno-fatal \
   --top-module io_board_tb -f filelist.f \
   --Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
   exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- source/bus_cmd_decode.sv
// bus controller that registers processor status into active-high I/O and memory command strobes
`timescale 1ns/1ps
`default_nettype none

module bus_cmd_decode
   import io_board_pkg::*;
(
   input  wire         clk,
   input  wire         reset_n,
   input  bus_status_e status_i,
   output logic        ior_o,
   output logic        iow_o,
   output logic        memr_o,
   output logic        memw_o
);

   logic ior_d;
   logic iow_d;
   logic memr_d;
   logic memw_d;

   // status decode with at most one command per bus cycle
   always_comb begin
      ior_d  = 1'b0;
      iow_d  = 1'b0;
      memr_d = 1'b0;
      memw_d = 1'b0;
      case (status_i)
         BUS_IOR:            ior_d  = 1'b1;
         BUS_IOW:            iow_d  = 1'b1;
         BUS_CODE, BUS_MEMR: memr_d = 1'b1; // fetch is a memory read on the bus
         BUS_MEMW:           memw_d = 1'b1;
         default: begin
            // inta, halt and passive drive no command
         end
      endcase
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         ior_o  <= 1'b0;
         iow_o  <= 1'b0;
         memr_o <= 1'b0;
         memw_o <= 1'b0;
      end else begin
         ior_o  <= ior_d;
         iow_o  <= iow_d;
         memr_o <= memr_d;
         memw_o <= memw_d;
      end
   end

   // commands are exclusive on every cycle
   a_cmd_onehot0 : assert property (
      @(posedge clk) disable iff (!reset_n)
      $onehot0({ior_o, iow_o, memr_o, memw_o})
   ) else $error("bus_cmd_decode: more than one command strobe high");

endmodule

`default_nettype wire

//--- source/io_board.sv
// top of the board I/O slice: bus command decode, port decode, speaker timer and PPI ports
`timescale 1ns/1ps
`default_nettype none

module io_board
   import io_board_pkg::*;
#(
   parameter logic [TONE_CNT_W-1:0] TONE_RELOAD    = 12'h533,
   parameter logic [TONE_CNT_W-1:0] TONE_THRESHOLD = 12'h299
)
(
   input  wire                  clk,
   input  wire                  reset_n,
   input  bus_status_e          status_i,
   input  wire [IO_ADDR_W-1:0]  addr_i,
   input  wire [DATA_W-1:0]     wr_data_i,
   input  wire                  audio_en_i,
   output logic                 ior_o,
   output logic                 iow_o,
   output logic                 memr_o,
   output logic                 memw_o,
   output io_dev_e              dev_sel_o,
   output logic [DATA_W-1:0]    rd_data_o,
   output logic                 speaker_o
);

   logic [1:0] port_idx;
   logic       tone_out;
   logic       tone_gate;

   bus_cmd_decode u_bus_cmd (
      .clk      (clk),
      .reset_n  (reset_n),
      .status_i (status_i),
      .ior_o    (ior_o),
      .iow_o    (iow_o),
      .memr_o   (memr_o),
      .memw_o   (memw_o)
   );

   io_port_decode u_port_dec (
      .ior_i      (ior_o),
      .iow_i      (iow_o),
      .addr_i     (addr_i),
      .dev_sel_o  (dev_sel_o), // also goes off-slice to the other chips
      .port_idx_o (port_idx)
   );

   tone_timer #(
      .TONE_RELOAD    (TONE_RELOAD),
      .TONE_THRESHOLD (TONE_THRESHOLD)
   ) u_tone (
      .clk         (clk),
      .reset_n     (reset_n),
      .tone_gate_i (tone_gate),
      .tone_out_o  (tone_out)
   );

   ppi_ports u_ppi (
      .clk         (clk),
      .reset_n     (reset_n),
      .ior_i       (ior_o),
      .iow_i       (iow_o),
      .dev_sel_i   (dev_sel_o),
      .port_idx_i  (port_idx),
      .wr_data_i   (wr_data_i),
      .tone_out_i  (tone_out),
      .audio_en_i  (audio_en_i),
      .tone_gate_o (tone_gate),
      .rd_data_o   (rd_data_o),
      .speaker_o   (speaker_o)
   );

endmodule

`default_nettype wire

//--- source/io_board_pkg.sv
// shared types and constants for the board I/O slice, imported by each module that uses them
`default_nettype none

package io_board_pkg;

   // bus widths
   localparam int IO_ADDR_W  = 10; // low I/O space only
   localparam int DATA_W     = 8;
   localparam int TONE_CNT_W = 12;

   // processor status as seen on S2..S0
   typedef enum logic [2:0] {
      BUS_INTA    = 3'b000, // interrupt acknowledge
      BUS_IOR     = 3'b001,
      BUS_IOW     = 3'b010,
      BUS_HALT    = 3'b011,
      BUS_CODE    = 3'b100, // code fetch
      BUS_MEMR    = 3'b101,
      BUS_MEMW    = 3'b110,
      BUS_PASSIVE = 3'b111
   } bus_status_e;

   // board chip selects, same order as the address decoder outputs
   typedef enum logic [2:0] {
      DEV_DMA      = 3'd0,
      DEV_PIC      = 3'd1,
      DEV_PIT      = 3'd2,
      DEV_PPI      = 3'd3,
      DEV_NMI_REG  = 3'd4,
      DEV_DMA_PAGE = 3'd5,
      DEV_NONE     = 3'd7
   } io_dev_e;

   // PPI port index, address bits 1:0
   localparam logic [1:0] PPI_PORT_A = 2'd0;
   localparam logic [1:0] PPI_PORT_B = 2'd1;
   localparam logic [1:0] PPI_PORT_C = 2'd2;

   // configuration switches, a closed switch reads as 0
   localparam logic [DATA_W-1:0] SW1_SETTING     = 8'b0010_1100;
   localparam logic [3:0]        SW2_HIGH_NIBBLE = 4'b0110; // port B bit 2 set
   localparam logic [3:0]        SW2_LOW_NIBBLE  = 4'b1110; // port B bit 2 clear

endpackage

`default_nettype wire

//--- source/io_port_decode.sv
// I/O address decoder: turns an I/O strobe and address into a board device select and port index
`timescale 1ns/1ps
`default_nettype none

module io_port_decode
   import io_board_pkg::*;
(
   input  wire                  ior_i,
   input  wire                  iow_i,
   input  wire [IO_ADDR_W-1:0]  addr_i,
   output io_dev_e              dev_sel_o,
   output logic [1:0]           port_idx_o
);

   logic dec_en;

   // only the first 256 ports belong to the system board
   assign dec_en = (ior_i | iow_i) & ~addr_i[9] & ~addr_i[8];

   // one select per 32-port block
   always_comb begin
      dev_sel_o = DEV_NONE;
      if (dec_en) begin
         case (addr_i[7:5])
            3'd0:    dev_sel_o = DEV_DMA;      // 0x00
            3'd1:    dev_sel_o = DEV_PIC;      // 0x20
            3'd2:    dev_sel_o = DEV_PIT;      // 0x40
            3'd3:    dev_sel_o = DEV_PPI;      // 0x60
            3'd4:    dev_sel_o = DEV_NMI_REG;  // 0x80
            3'd5:    dev_sel_o = DEV_DMA_PAGE; // 0xa0
            default: dev_sel_o = DEV_NONE;     // 0xc0 and 0xe0 unused
         endcase
      end
   end

   assign port_idx_o = addr_i[1:0]; // register select inside the device

   // no device may respond outside an I/O command
   always_comb begin
      if (!(ior_i || iow_i)) begin
         a_sel_idle : assert (dev_sel_o == DEV_NONE)
            else $error("io_port_decode: device selected without an I/O strobe");
      end
   end

endmodule

`default_nettype wire

//--- source/ppi_ports.sv
// peripheral interface: port B latch, speaker drive and port A/B/C readback with config switches
`timescale 1ns/1ps
`default_nettype none

module ppi_ports
   import io_board_pkg::*;
(
   input  wire               clk,
   input  wire               reset_n,
   input  wire               ior_i,
   input  wire               iow_i,
   input  io_dev_e           dev_sel_i,
   input  wire [1:0]         port_idx_i,
   input  wire [DATA_W-1:0]  wr_data_i,
   input  wire               tone_out_i,
   input  wire               audio_en_i,
   output logic              tone_gate_o,
   output logic [DATA_W-1:0] rd_data_o,
   output logic              speaker_o
);

   logic [DATA_W-1:0] port_b_q;
   logic              ppi_sel;
   logic              spkr_data;
   logic [3:0]        sw2_nibble;
   logic [DATA_W-1:0] port_a_val;
   logic [DATA_W-1:0] port_c_val;

   assign ppi_sel = (dev_sel_i == DEV_PPI);

   // port B output latch
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         port_b_q <= '0;
      end else if (iow_i && ppi_sel && port_idx_i == PPI_PORT_B) begin
         port_b_q <= wr_data_i;
      end
   end

   assign tone_gate_o = port_b_q[0]; // timer 2 gate
   assign spkr_data   = port_b_q[1];

   // speaker driver inverts the mixed tone
   assign speaker_o = audio_en_i ? ~(tone_out_i & spkr_data) : 1'b1;

   // port A shows switch block 1 when bit 7 selects it
   assign port_a_val = port_b_q[7] ? SW1_SETTING : '0;

   // port C low nibble is half of switch block 2
   assign sw2_nibble = port_b_q[2] ? SW2_HIGH_NIBBLE : SW2_LOW_NIBBLE;
   assign port_c_val = {2'b00, tone_out_i, ~tone_out_i, sw2_nibble};

   // read mux, zero unless the PPI is being read
   always_comb begin
      rd_data_o = '0;
      if (ior_i && ppi_sel) begin
         case (port_idx_i)
            PPI_PORT_A: rd_data_o = port_a_val;
            PPI_PORT_B: rd_data_o = port_b_q;
            PPI_PORT_C: rd_data_o = port_c_val;
            default:    rd_data_o = '0; // control port is write only
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/tone_timer.sv
// speaker tone generator: half-rate prescaler, reloading down counter and gated square output
`timescale 1ns/1ps
`default_nettype none

module tone_timer
   import io_board_pkg::*;
#(
   parameter logic [TONE_CNT_W-1:0] TONE_RELOAD    = 12'h533,
   parameter logic [TONE_CNT_W-1:0] TONE_THRESHOLD = 12'h299
)
(
   input  wire  clk,
   input  wire  reset_n,
   input  wire  tone_gate_i,
   output logic tone_out_o
);

   logic                  prescale_q;
   logic [TONE_CNT_W-1:0] count_q;
   logic                  tone_raw;

   // timer clock enable at half the board clock
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         prescale_q <= 1'b0;
      end else begin
         prescale_q <= ~prescale_q;
      end
   end

   // down counter, reload at terminal count
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         count_q <= TONE_RELOAD;
      end else if (prescale_q) begin
         if (count_q == '0) begin
            count_q <= TONE_RELOAD;
         end else begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   // high for the upper part of the count
   assign tone_raw = (count_q >= TONE_THRESHOLD);

   // gate low parks the output high
   assign tone_out_o = tone_gate_i ? tone_raw : 1'b1;

   // reload value bounds the count
   a_count_range : assert property (
      @(posedge clk) disable iff (!reset_n)
      count_q <= TONE_RELOAD
   ) else $error("tone_timer: count above reload value");

endmodule

`default_nettype wire
